/* common/hrtf_defines.svh */
// HRTF coefficient subsystem sizing
// Tap count, direction grid, coefficient and SRAM widths, stream count
// and the base address of the right-ear half of the coefficient SRAM

`ifndef HRTF_DEFINES_SVH
`define HRTF_DEFINES_SVH

// FIR taps held per ear for one direction
`define HRTF_NUM_TAPS 200

// Measured direction grid, azimuth by elevation
`define HRTF_NUM_AZ 25
`define HRTF_NUM_EL 25

// Signed coefficient word as stored in the SRAM and the banks
`define HRTF_COEF_WIDTH 17

// Word address width of the external coefficient SRAM
`define HRTF_SRAM_AW 18

// Independent audio streams, each with its own double-buffered banks
`define HRTF_NUM_STREAMS 2

// Right-ear sets start after all 625 left-ear sets of 200 taps
`define HRTF_RIGHT_OFFSET 125000

`endif

/* common/hrtf_pkg.sv */
// HRTF coefficient subsystem types
// Register word views, AXI response codes and the ear selector

package hrtf_pkg;

  // Command view of register 0, as decoded on a host write
  typedef struct packed {
    logic [16:0] reserved;
    logic [3:0]  stream;
    logic [5:0]  elevation;
    logic [4:0]  azimuth;
  } cmdFields;

  // Status view of register 0, as returned on a host read
  typedef struct packed {
    logic [28:0] reserved;
    logic        select1;
    logic        select0;
    logic        busy;
  } statusFields;

  // Register 0 means a command when written and the status when read
  typedef union packed {
    cmdFields    cmd;
    statusFields status;
  } regWord;

  // Ear that a coefficient set belongs to, also the bank index
  typedef enum logic {
    EAR_LEFT  = 1'b0,
    EAR_RIGHT = 1'b1
  } earType;

  // AXI write and read response codes
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

/* common/hrtf_if.sv */
// Internal links of the HRTF coefficient subsystem
// updateCmd_if carries a validated command from the registers to the updater,
// coeffWrite_if carries the coefficient stream from the updater into the banks

`include "hrtf_defines.svh"

interface updateCmd_if;
  logic [4:0] azimuth;
  logic [5:0] elevation;
  logic [3:0] stream;
  logic       start;
  logic       busy;

  modport regs (output azimuth, elevation, stream, start, input busy);
  modport updater (input azimuth, elevation, stream, start, output busy);
endinterface

interface coeffWrite_if;
  logic [7:0]                  tapAddr;
  logic [`HRTF_COEF_WIDTH-1:0] data;
  hrtf_pkg::earType            ear;
  logic [3:0]                  stream;
  logic                        we;
  logic                        commit;

  modport updater (output tapAddr, data, ear, stream, we, commit);
  modport banks (input tapAddr, data, ear, stream, we, commit);
endinterface

/* verilog/hrtfRegs.sv */
// HRTF command and status registers
// AXI4-Lite slave with one register at offset 0. A write is a direction
// command that is range-checked and handed to the updater, a read returns
// the busy flag and the page selects of both streams

`include "hrtf_defines.svh"

module hrtfRegs (
  input  logic                         Clock,
  input  logic                         rst,
  input  logic [31:0]                  awaddr,
  input  logic                         awvalid,
  output logic                         awready,
  input  logic [31:0]                  wdata,
  input  logic                         wvalid,
  output logic                         wready,
  output logic [1:0]                   bresp,
  output logic                         bvalid,
  input  logic                         bready,
  input  logic [31:0]                  araddr,
  input  logic                         arvalid,
  output logic                         arready,
  output logic [31:0]                  rdata,
  output logic [1:0]                   rresp,
  output logic                         rvalid,
  input  logic                         rready,
  updateCmd_if.regs                    cmd,
  input  logic [`HRTF_NUM_STREAMS-1:0] selects
);

  logic             awHeld;
  logic             wHeld;
  logic [31:0]      addrReg;
  logic [31:0]      dataReg;
  logic             awFire;
  logic             wFire;
  logic             arFire;
  logic             writeGo;
  logic [31:0]      writeAddr;
  hrtf_pkg::regWord writeWord;
  hrtf_pkg::regWord statusWord;
  logic             fieldsValid;
  logic             cmdAccept;

  // Each half of a write is taken once and held until its partner arrives.
  // No new write is taken while a response is still pending
  assign awready = !awHeld && !bvalid;
  assign wready  = !wHeld && !bvalid;
  assign awFire  = awvalid && awready;
  assign wFire   = wvalid && wready;

  // Use the half that arrives this cycle, else the one that was held
  assign writeAddr = awFire ? awaddr : addrReg;
  assign writeWord = wFire ? wdata : dataReg;
  assign writeGo   = (awFire || awHeld) && (wFire || wHeld);

  // A command must point inside the direction grid and at an existing stream
  assign fieldsValid = (writeWord.cmd.azimuth < `HRTF_NUM_AZ) &&
                       (writeWord.cmd.elevation < `HRTF_NUM_EL) &&
                       (writeWord.cmd.stream < `HRTF_NUM_STREAMS);

  // Only offset 0 takes commands, and only while the updater is idle
  assign cmdAccept = (writeAddr == '0) && fieldsValid && !cmd.busy;

  always_ff @(posedge Clock) begin
    if (rst) begin
      awHeld    <= 1'b0;
      wHeld     <= 1'b0;
      bvalid    <= 1'b0;
      cmd.start <= 1'b0;
    end else begin
      // Start lines up with the write response
      cmd.start <= writeGo && cmdAccept;
      if (writeGo) begin
        awHeld <= 1'b0;
        wHeld  <= 1'b0;
        bvalid <= 1'b1;
      end else begin
        if (awFire) awHeld <= 1'b1;
        if (wFire) wHeld <= 1'b1;
        if (bvalid && bready) bvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge Clock) begin
    if (awFire) addrReg <= awaddr;
    if (wFire) dataReg <= wdata;
    if (writeGo) bresp <= cmdAccept ? hrtf_pkg::RESP_OKAY : hrtf_pkg::RESP_SLVERR;
    // The fields stay stable for the whole update that they start
    if (writeGo && cmdAccept) begin
      cmd.azimuth   <= writeWord.cmd.azimuth;
      cmd.elevation <= writeWord.cmd.elevation;
      cmd.stream    <= writeWord.cmd.stream;
    end
  end

  // Status word seen by the host
  always_comb begin
    statusWord                = '0;
    statusWord.status.busy    = cmd.busy;
    statusWord.status.select0 = selects[0];
    statusWord.status.select1 = selects[1];
  end

  // One read in flight, answered in the cycle after the address
  assign arready = !rvalid;
  assign arFire  = arvalid && arready;

  always_ff @(posedge Clock) begin
    if (rst) begin
      rvalid <= 1'b0;
    end else if (arFire) begin
      rvalid <= 1'b1;
    end else if (rready) begin
      rvalid <= 1'b0;
    end
  end

  always_ff @(posedge Clock) begin
    if (arFire) begin
      rdata <= (araddr == '0) ? statusWord : '0;
      rresp <= (araddr == '0) ? hrtf_pkg::RESP_OKAY : hrtf_pkg::RESP_SLVERR;
    end
  end

endmodule

/* coeffUpdater/coeffUpdater.sv */
// HRTF coefficient updater
// On start, copies the left-ear then the right-ear set of the commanded
// direction from the coefficient SRAM into the inactive page of the stream's
// banks, then commits so that the stream switches to the new page

`include "hrtf_defines.svh"

module coeffUpdater (
  input  logic                         Clock,
  input  logic                         rst,
  updateCmd_if.updater                 cmd,
  coeffWrite_if.updater                wr,
  output logic [`HRTF_SRAM_AW-1:0]     sramAddr,
  output logic                         sramReadEnable,
  input  logic [`HRTF_COEF_WIDTH-1:0]  sramReadData
);

  // One-hot state bit positions
  localparam int S_IDLE    = 0;
  localparam int S_START_L = 1;
  localparam int S_UPD_L   = 2;
  localparam int S_START_R = 3;
  localparam int S_UPD_R   = 4;

  logic [4:0]               state;
  logic [7:0]               tapCount;
  logic                     lastTap;
  logic [`HRTF_SRAM_AW-1:0] baseLeft;
  logic [`HRTF_SRAM_AW-1:0] baseRight;
  logic [7:0]               tapReg;
  hrtf_pkg::earType         earReg;
  logic                     weReg;
  logic                     commitReg;
  logic                     busyReg;
  logic                     finalWrite;

  assign lastTap = (tapCount == 8'(`HRTF_NUM_TAPS - 1));

  // Sets are laid out azimuth-major, one elevation row after the other
  assign baseLeft  = `HRTF_SRAM_AW'(cmd.azimuth * (`HRTF_NUM_EL * `HRTF_NUM_TAPS) +
                                    cmd.elevation * `HRTF_NUM_TAPS);
  assign baseRight = baseLeft + `HRTF_SRAM_AW'(`HRTF_RIGHT_OFFSET);

  always_ff @(posedge Clock) begin
    if (rst) begin
      state <= 5'b00001;
    end else begin
      state[S_IDLE]    <= (state[S_IDLE] && !cmd.start) || (state[S_UPD_R] && lastTap);
      state[S_START_L] <= state[S_IDLE] && cmd.start;
      state[S_UPD_L]   <= state[S_START_L] || (state[S_UPD_L] && !lastTap);
      state[S_START_R] <= state[S_UPD_L] && lastTap;
      state[S_UPD_R]   <= state[S_START_R] || (state[S_UPD_R] && !lastTap);
    end
  end

  // The SRAM is read on every cycle of both update states
  assign sramReadEnable = state[S_UPD_L] || state[S_UPD_R];

  // The start states load the set base and clear the tap count
  always_ff @(posedge Clock) begin
    if (state[S_START_L]) begin
      sramAddr <= baseLeft;
    end else if (state[S_START_R]) begin
      sramAddr <= baseRight;
    end else if (sramReadEnable) begin
      sramAddr <= sramAddr + 1'b1;
    end

    if (state[S_START_L] || state[S_START_R]) begin
      tapCount <= '0;
    end else if (sramReadEnable) begin
      tapCount <= tapCount + 1'b1;
    end

    // Write address and ear trail the read by the SRAM latency.
    // They hold after the last read so commit still sees tap 199 right
    if (sramReadEnable) begin
      tapReg <= tapCount;
      earReg <= state[S_UPD_R] ? hrtf_pkg::EAR_RIGHT : hrtf_pkg::EAR_LEFT;
    end
  end

  // Last right-ear tap being written this cycle
  assign finalWrite = weReg && (earReg == hrtf_pkg::EAR_RIGHT) &&
                      (tapReg == 8'(`HRTF_NUM_TAPS - 1));

  always_ff @(posedge Clock) begin
    if (rst) begin
      weReg     <= 1'b0;
      commitReg <= 1'b0;
      busyReg   <= 1'b0;
    end else begin
      weReg     <= sramReadEnable;
      commitReg <= finalWrite;
      // Busy covers the whole copy, and drops together with commit
      busyReg   <= (busyReg && !finalWrite) || (state[S_IDLE] && cmd.start);
    end
  end

  assign cmd.busy   = busyReg;
  assign wr.tapAddr = tapReg;
  // SRAM data arrives in the same cycle as its delayed write strobe
  assign wr.data    = sramReadData;
  assign wr.ear     = earReg;
  assign wr.stream  = cmd.stream;
  assign wr.we      = weReg;
  assign wr.commit  = commitReg;

endmodule

/* verilog/coeffBanks.sv */
// HRTF coefficient banks
// Two pages of left and right coefficients per stream. The updater fills
// the page not in use, a commit flips the stream's select, and the filter
// port reads the selected page with one cycle of latency

`include "hrtf_defines.svh"

module coeffBanks (
  input  logic                                 Clock,
  input  logic                                 rst,
  coeffWrite_if.banks                          wr,
  input  logic [$clog2(`HRTF_NUM_STREAMS)-1:0] readStream,
  input  logic [7:0]                           readTap,
  output logic [`HRTF_COEF_WIDTH-1:0]          coefLeft,
  output logic [`HRTF_COEF_WIDTH-1:0]          coefRight,
  output logic [`HRTF_NUM_STREAMS-1:0]         selects
);

  localparam int SW = $clog2(`HRTF_NUM_STREAMS);

  // Indexed by stream, ear, page and tap
  logic [`HRTF_COEF_WIDTH-1:0] bankMem [`HRTF_NUM_STREAMS][2][2][`HRTF_NUM_TAPS];

  logic [SW-1:0] wrStream;
  logic          wrPage;
  logic          readPage;

  // The updater only sends streams that passed the register check
  assign wrStream = wr.stream[SW-1:0];

  // Writes always land in the page the filters are not reading
  assign wrPage = ~selects[wrStream];

  always_ff @(posedge Clock) begin
    if (wr.we) begin
      bankMem[wrStream][wr.ear][wrPage][wr.tapAddr] <= wr.data;
    end
  end

  // Commit makes the freshly written page active from the next cycle on
  always_ff @(posedge Clock) begin
    if (rst) begin
      selects <= '0;
    end else if (wr.commit) begin
      selects[wrStream] <= ~selects[wrStream];
    end
  end

  assign readPage = selects[readStream];

  // Both ears are read together for the requested stream and tap
  always_ff @(posedge Clock) begin
    coefLeft  <= bankMem[readStream][hrtf_pkg::EAR_LEFT][readPage][readTap];
    coefRight <= bankMem[readStream][hrtf_pkg::EAR_RIGHT][readPage][readTap];
  end

endmodule

/* verilog/hrtfCoeffTop.sv */
// HRTF coefficient loading subsystem
// AXI4-Lite command registers, the SRAM-to-bank updater and the
// double-buffered coefficient banks with the filter read port

`include "hrtf_defines.svh"

module hrtfCoeffTop (
  input  logic                                 Clock,
  input  logic                                 rst,
  input  logic [31:0]                          awaddr,
  input  logic                                 awvalid,
  output logic                                 awready,
  input  logic [31:0]                          wdata,
  input  logic                                 wvalid,
  output logic                                 wready,
  output logic [1:0]                           bresp,
  output logic                                 bvalid,
  input  logic                                 bready,
  input  logic [31:0]                          araddr,
  input  logic                                 arvalid,
  output logic                                 arready,
  output logic [31:0]                          rdata,
  output logic [1:0]                           rresp,
  output logic                                 rvalid,
  input  logic                                 rready,
  output logic [`HRTF_SRAM_AW-1:0]             sramAddr,
  output logic                                 sramReadEnable,
  input  logic [`HRTF_COEF_WIDTH-1:0]          sramReadData,
  input  logic [$clog2(`HRTF_NUM_STREAMS)-1:0] readStream,
  input  logic [7:0]                           readTap,
  output logic [`HRTF_COEF_WIDTH-1:0]          coefLeft,
  output logic [`HRTF_COEF_WIDTH-1:0]          coefRight,
  output logic [`HRTF_NUM_STREAMS-1:0]         filterSelect
);

  updateCmd_if  cmdLink ();
  coeffWrite_if writeLink ();

  // Register block sees the selects for its status word
  hrtfRegs regs (
    .Clock   (Clock),
    .rst     (rst),
    .awaddr  (awaddr),
    .awvalid (awvalid),
    .awready (awready),
    .wdata   (wdata),
    .wvalid  (wvalid),
    .wready  (wready),
    .bresp   (bresp),
    .bvalid  (bvalid),
    .bready  (bready),
    .araddr  (araddr),
    .arvalid (arvalid),
    .arready (arready),
    .rdata   (rdata),
    .rresp   (rresp),
    .rvalid  (rvalid),
    .rready  (rready),
    .cmd     (cmdLink.regs),
    .selects (filterSelect)
  );

  coeffUpdater updater (
    .Clock          (Clock),
    .rst            (rst),
    .cmd            (cmdLink.updater),
    .wr             (writeLink.updater),
    .sramAddr       (sramAddr),
    .sramReadEnable (sramReadEnable),
    .sramReadData   (sramReadData)
  );

  coeffBanks banks (
    .Clock      (Clock),
    .rst        (rst),
    .wr         (writeLink.banks),
    .readStream (readStream),
    .readTap    (readTap),
    .coefLeft   (coefLeft),
    .coefRight  (coefRight),
    .selects    (filterSelect)
  );

endmodule

/* test/clockGen.sv */
// Testbench clock source
// Free-running clock with a period of 100 time units, low at time zero

module clockGen (
  output logic Clock
);

  initial begin
    Clock = 1'b0;
  end

  // Half period of 50 gives the full period of 100
  always #50 Clock = ~Clock;

endmodule

/* test/coeffUpdater_checker.sv */
// Updater write sequence checks
// Start, write and commit strobes against busy, tap and ear, and the
// SRAM read enable against the idle state of the sequencer

`include "hrtf_defines.svh"

module coeffUpdater_checker (
  input logic       Clock,
  input logic       rst,
  input logic       start,
  input logic       busy,
  input logic       we,
  input logic       commit,
  input logic [7:0] tapAddr,
  input logic       ear,
  input logic       idle,
  input logic       sramReadEnable
);

  // A new command may only arrive while the updater is free
  startNotBusy: assert property (@(posedge Clock) disable iff (rst) start |-> !busy)
    else $error("Start pulse arrived while the updater was busy");

  // Bank writes belong to a running update
  writeWhileBusy: assert property (@(posedge Clock) disable iff (rst) we |-> busy)
    else $error("Bank write strobe seen while the updater was not busy");

  // Commit follows the final right-ear tap and nothing else
  commitAtLastTap: assert property (@(posedge Clock) disable iff (rst)
    commit |-> (tapAddr == 8'(`HRTF_NUM_TAPS - 1)) && ear)
    else $error("Commit pulse not aligned with the last right-ear tap");

  // No SRAM traffic from the idle state
  noReadWhenIdle: assert property (@(posedge Clock) disable iff (rst) idle |-> !sramReadEnable)
    else $error("SRAM read enable high while the updater was idle");

endmodule

/* test/hrtfCoeffTb.sv */
// HRTF coefficient subsystem testbench
// Random direction commands over AXI4-Lite against an SRAM model, with a
// reference model of the page selects and the active set of each stream

`include "hrtf_defines.svh"

module hrtfCoeffTb;

  localparam int HANDSHAKE_LIMIT = 50;
  localparam int POLL_LIMIT      = 300;

  logic                                 Clock;
  logic                                 rst;
  logic [31:0]                          awaddr;
  logic                                 awvalid;
  logic                                 awready;
  logic [31:0]                          wdata;
  logic                                 wvalid;
  logic                                 wready;
  logic [1:0]                           bresp;
  logic                                 bvalid;
  logic                                 bready;
  logic [31:0]                          araddr;
  logic                                 arvalid;
  logic                                 arready;
  logic [31:0]                          rdata;
  logic [1:0]                           rresp;
  logic                                 rvalid;
  logic                                 rready;
  logic [`HRTF_SRAM_AW-1:0]             sramAddr;
  logic                                 sramReadEnable;
  logic [`HRTF_COEF_WIDTH-1:0]          sramReadData;
  logic [$clog2(`HRTF_NUM_STREAMS)-1:0] readStream;
  logic [7:0]                           readTap;
  logic [`HRTF_COEF_WIDTH-1:0]          coefLeft;
  logic [`HRTF_COEF_WIDTH-1:0]          coefRight;
  logic [`HRTF_NUM_STREAMS-1:0]         filterSelect;

  int mismatchCount = 0;
  int timeoutCount = 0;

  // Reference model, the active set of each stream and the expected selects
  int   modelAz [`HRTF_NUM_STREAMS];
  int   modelEl [`HRTF_NUM_STREAMS];
  bit   modelValid [`HRTF_NUM_STREAMS];
  logic [`HRTF_NUM_STREAMS-1:0] modelSel;

  clockGen clkGen (.Clock(Clock));

  hrtfCoeffTop uut (
    .Clock(Clock), .rst(rst),
    .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
    .wdata(wdata), .wvalid(wvalid), .wready(wready),
    .bresp(bresp), .bvalid(bvalid), .bready(bready),
    .araddr(araddr), .arvalid(arvalid), .arready(arready),
    .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
    .sramAddr(sramAddr), .sramReadEnable(sramReadEnable), .sramReadData(sramReadData),
    .readStream(readStream), .readTap(readTap),
    .coefLeft(coefLeft), .coefRight(coefRight), .filterSelect(filterSelect)
  );

  bind coeffUpdater coeffUpdater_checker updaterChecks (
    .Clock          (Clock),
    .rst            (rst),
    .start          (cmd.start),
    .busy           (busyReg),
    .we             (weReg),
    .commit         (commitReg),
    .tapAddr        (tapReg),
    .ear            (earReg),
    .idle           (state[0]),
    .sramReadEnable (sramReadEnable)
  );

  // Coefficient content of the SRAM, a mix of all address bits
  function automatic logic [16:0] hashAddr(input logic [17:0] addr);
    logic [31:0] mixed;
    mixed = {14'd0, addr} * 32'd2654435;
    mixed = mixed ^ (mixed >> 13);
    return mixed[16:0];
  endfunction

  // Set base in the SRAM, right ears live in the upper half
  function automatic logic [17:0] setAddr(input int az, input int el, input bit rightEar);
    int addr;
    addr = 5000 * az + 200 * el;
    if (rightEar) addr = addr + `HRTF_RIGHT_OFFSET;
    return addr[17:0];
  endfunction

  // Command word, azimuth in bits 4:0, elevation 10:5, stream 14:11
  function automatic logic [31:0] packCmd(input logic [31:0] az, input logic [31:0] el,
                                          input logic [31:0] stream);
    return {17'd0, stream[3:0], el[5:0], az[4:0]};
  endfunction

  // SRAM answers one cycle after the address
  always @(posedge Clock) begin
    if (sramReadEnable) sramReadData <= hashAddr(sramAddr);
  end

  task automatic reportMismatch(input string msg);
    mismatchCount++;
    $display("MISMATCH at time %0t: %s", $time, msg);
  endtask

  task automatic finishRun;
    $display("Errors: %0d mismatches, %0d timeouts", mismatchCount, timeoutCount);
    if (mismatchCount == 0 && timeoutCount == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  endtask

  task automatic reportTimeout(input string what);
    timeoutCount++;
    $display("Timeout at time %0t: the DUT never gave the %s, stopping", $time, what);
    finishRun();
  endtask

  // Address and data are offered together, each drops once taken
  task automatic axiWrite(input logic [31:0] addr, input logic [31:0] data,
                          output logic [1:0] resp);
    int cycles;
    bit addrDone;
    bit dataDone;
    bit respDone;
    addrDone = 0;
    dataDone = 0;
    respDone = 0;
    cycles = 0;
    @(posedge Clock);
    awaddr  <= addr;
    awvalid <= 1'b1;
    wdata   <= data;
    wvalid  <= 1'b1;
    bready  <= 1'b1;
    while (!(addrDone && dataDone)) begin
      @(posedge Clock);
      cycles++;
      if (awvalid && awready) begin
        addrDone = 1;
        awvalid <= 1'b0;
      end
      if (wvalid && wready) begin
        dataDone = 1;
        wvalid <= 1'b0;
      end
      if (!(addrDone && dataDone) && cycles > HANDSHAKE_LIMIT) reportTimeout("write accept");
    end
    cycles = 0;
    while (!respDone) begin
      @(posedge Clock);
      cycles++;
      if (bvalid) begin
        respDone = 1;
        resp = bresp;
        bready <= 1'b0;
      end else if (cycles > HANDSHAKE_LIMIT) begin
        reportTimeout("write response");
      end
    end
  endtask

  task automatic axiRead(input logic [31:0] addr, output logic [31:0] data,
                         output logic [1:0] resp);
    int cycles;
    bit addrDone;
    bit dataDone;
    addrDone = 0;
    dataDone = 0;
    cycles = 0;
    @(posedge Clock);
    araddr  <= addr;
    arvalid <= 1'b1;
    rready  <= 1'b1;
    while (!addrDone) begin
      @(posedge Clock);
      cycles++;
      if (arready) begin
        addrDone = 1;
        arvalid <= 1'b0;
      end else if (cycles > HANDSHAKE_LIMIT) begin
        reportTimeout("read address accept");
      end
    end
    cycles = 0;
    while (!dataDone) begin
      @(posedge Clock);
      cycles++;
      if (rvalid) begin
        dataDone = 1;
        data = rdata;
        resp = rresp;
        rready <= 1'b0;
      end else if (cycles > HANDSHAKE_LIMIT) begin
        reportTimeout("read data");
      end
    end
  endtask

  // Status bit 0 is busy, bits 2:1 are the selects of streams 0 and 1
  task automatic readStatus(output logic busy, output logic [1:0] sel);
    logic [31:0] data;
    logic [1:0]  resp;
    axiRead(32'd0, data, resp);
    if (resp != hrtf_pkg::RESP_OKAY) reportMismatch("status read did not return OKAY");
    busy = data[0];
    sel  = data[2:1];
  endtask

  // Both the status word and the filter port must show the model's selects
  task automatic checkIdle;
    logic       busy;
    logic [1:0] sel;
    readStatus(busy, sel);
    if (busy) reportMismatch("busy set with no update running");
    if (sel != modelSel) reportMismatch($sformatf("selects %b, expected %b", sel, modelSel));
    if (filterSelect != modelSel) begin
      reportMismatch($sformatf("filterSelect %b, expected %b", filterSelect, modelSel));
    end
  endtask

  // Random taps of one stream against the active set of the model
  task automatic checkTaps(input int stream, input int count);
    int tap;
    logic [16:0] expLeft;
    logic [16:0] expRight;
    for (int i = 0; i < count; i++) begin
      tap = $urandom_range(0, `HRTF_NUM_TAPS - 1);
      @(posedge Clock);
      readStream <= stream;
      readTap    <= tap;
      // Data is registered at the next edge and sampled one edge later
      @(posedge Clock);
      @(posedge Clock);
      if (modelValid[stream]) begin
        expLeft  = hashAddr(setAddr(modelAz[stream], modelEl[stream], 1'b0) + 18'(tap));
        expRight = hashAddr(setAddr(modelAz[stream], modelEl[stream], 1'b1) + 18'(tap));
        if (coefLeft != expLeft || coefRight != expRight) begin
          reportMismatch($sformatf("stream %0d tap %0d got %h/%h, expected %h/%h", stream,
                                   tap, coefLeft, coefRight, expLeft, expRight));
        end
      end
    end
  endtask

  // Out-of-grid command, wrong offset and bad read all answer SLVERR
  task automatic rejectInvalid;
    int az;
    int el;
    int stream;
    logic [1:0]  resp;
    logic [31:0] data;
    az = $urandom_range(0, 24);
    el = $urandom_range(0, 24);
    stream = $urandom_range(0, 1);
    case ($urandom_range(0, 2))
      0: az = $urandom_range(25, 31);
      1: el = $urandom_range(25, 63);
      default: stream = $urandom_range(2, 15);
    endcase
    axiWrite(32'd0, packCmd(az, el, stream), resp);
    if (resp != hrtf_pkg::RESP_SLVERR) reportMismatch("out-of-range command not rejected");
    axiWrite(32'd4, packCmd(1, 1, 0), resp);
    if (resp != hrtf_pkg::RESP_SLVERR) reportMismatch("write to offset 4 not rejected");
    axiRead(32'd8, data, resp);
    if (resp != hrtf_pkg::RESP_SLVERR || data != 0) reportMismatch("read of offset 8 wrong");
    checkIdle();
  endtask

  // One accepted command followed until completion
  task automatic runUpdate(input int stream, input int az, input int el, input bit overlap);
    logic [1:0] resp;
    logic       busy;
    logic [1:0] sel;
    int         polls;
    axiWrite(32'd0, packCmd(az, el, stream), resp);
    if (resp != hrtf_pkg::RESP_OKAY) reportMismatch("valid command not accepted");
    readStatus(busy, sel);
    if (!busy) reportMismatch("busy not set after an accepted command");
    // The filters keep the previous set while the copy runs
    checkTaps(stream, 3);
    if (overlap) begin
      axiWrite(32'd0, packCmd($urandom_range(0, 24), $urandom_range(0, 24),
                              $urandom_range(0, 1)), resp);
      if (resp != hrtf_pkg::RESP_SLVERR) reportMismatch("command while busy not rejected");
    end
    polls = 0;
    while (busy) begin
      readStatus(busy, sel);
      polls++;
      if (busy && polls > POLL_LIMIT) reportTimeout("end of the update");
    end
    modelAz[stream]    = az;
    modelEl[stream]    = el;
    modelValid[stream] = 1;
    modelSel[stream]   = ~modelSel[stream];
    // The select flips one cycle after busy falls, so status is read again
    checkIdle();
    checkTaps(stream, 6);
  endtask

  initial begin
    void'($urandom(9639));
    rst          = 1'b1;
    awaddr       = '0;
    awvalid      = 1'b0;
    wdata        = '0;
    wvalid       = 1'b0;
    bready       = 1'b0;
    araddr       = '0;
    arvalid      = 1'b0;
    rready       = 1'b0;
    sramReadData = '0;
    readStream   = '0;
    readTap      = '0;
    modelSel     = '0;
    for (int s = 0; s < `HRTF_NUM_STREAMS; s++) begin
      modelValid[s] = 0;
    end
    repeat (5) @(posedge Clock);
    rst <= 1'b0;

    checkIdle();
    repeat (4) rejectInvalid();
    runUpdate($urandom_range(0, 1), $urandom_range(0, 24), $urandom_range(0, 24), 1'b0);
    runUpdate($urandom_range(0, 1), $urandom_range(0, 24), $urandom_range(0, 24), 1'b1);
    // Mixed traffic to both streams
    repeat (6) begin
      runUpdate($urandom_range(0, 1), $urandom_range(0, 24), $urandom_range(0, 24),
                $urandom_range(0, 1));
    end
    rejectInvalid();
    checkTaps(0, 8);
    checkTaps(1, 8);
    checkIdle();
    finishRun();
  end

endmodule

/* compile.f */
+incdir+common
common/hrtf_pkg.sv
common/hrtf_if.sv
verilog/hrtfRegs.sv
coeffUpdater/coeffUpdater.sv
verilog/coeffBanks.sv
verilog/hrtfCoeffTop.sv
test/clockGen.sv
test/coeffUpdater_checker.sv
test/hrtfCoeffTb.sv

/* Bender.yml */
package:
  name: hrtf_coeff

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/hrtf_pkg.sv
      - common/hrtf_if.sv
      - verilog/hrtfRegs.sv
      - coeffUpdater/coeffUpdater.sv
      - verilog/coeffBanks.sv
      - verilog/hrtfCoeffTop.sv
  - target: test
    include_dirs:
      - common
    files:
      - test/clockGen.sv
      - test/coeffUpdater_checker.sv
      - test/hrtfCoeffTb.sv
